/* common/eth_mac_pkg.sv */
package eth_mac_pkg;

	// --------------------------------------------------------------------------
	// sizes

	localparam int PKT_BYTES  = 64;                   // max stored frame incl. FCS
	localparam int RING_DEPTH = 4;
	localparam int BYTE_IDX_W = $clog2(PKT_BYTES);
	localparam int RING_IDX_W = $clog2(RING_DEPTH);
	localparam int LEN_W      = $clog2(PKT_BYTES + 1);
	localparam int APB_ADDR_W = 12;
	localparam int APB_DATA_W = 32;

	// --------------------------------------------------------------------------
	// framing

	localparam logic [7:0]  PREAMBLE_BYTE = 8'h55;
	localparam int          PREAMBLE_LEN  = 7;
	localparam logic [7:0]  SFD_BYTE      = 8'hD5;
	localparam int          FCS_LEN       = 4;
	localparam int          IFG_CYCLES    = 12;
	localparam logic [31:0] CRC_POLY      = 32'h04C1_1DB7;
	localparam logic [31:0] CRC_INIT      = 32'hFFFF_FFFF;
	localparam logic [31:0] CRC_RESIDUE   = 32'hC704_DD7B;

	typedef enum logic [2:0] {
		OP_RX_BYTE,
		OP_RX_LEN,
		OP_RX_NEXT,
		OP_TX_BYTE,
		OP_TX_LEN,
		OP_TX_NEXT
	} host_op_e;

	typedef enum logic [2:0] {
		TX_IDLE,
		TX_PREAMBLE,
		TX_SFD,
		TX_DATA,
		TX_FCS,
		TX_GAP
	} tx_state_e;

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_PREAMBLE,
		RX_DATA,
		RX_DISCARD
	} rx_state_e;

	typedef struct packed {
		logic       valid;
		logic       write;
		host_op_e   op;
		logic [7:0] index;
		logic [7:0] wdata;
	} host_req_t;

	typedef struct packed {
		logic [7:0] rdata;                            // byte or length
		logic       err;
	} store_rsp_t;

	typedef struct packed {
		logic [7:0] data;
		logic       en;
		logic       er;
	} gmii_t;

	typedef struct packed {
		logic             valid;
		logic [LEN_W-1:0] len;
	} tx_head_t;

	typedef struct packed {
		logic                  we;
		logic [BYTE_IDX_W-1:0] index;
		logic [7:0]            data;
		logic                  commit;
		logic                  drop;
		logic [LEN_W-1:0]      len;
	} rx_wr_t;

	// data bit 0 enters first, register kept in normal (x^31 at bit 31) order
	function automatic logic [31:0] crc32_next(input logic [7:0] data, input logic [31:0] crc);
		logic [31:0] c;
		c = crc;
		for (int i = 0; i < 8; i++) begin
			c = {c[30:0], 1'b0} ^ ((c[31] ^ data[i]) ? CRC_POLY : 32'h0);
		end
		return c;
	endfunction

	// wire byte of the FCS taken from the top byte of the register
	function automatic logic [7:0] fcs_byte(input logic [31:0] crc);
		logic [7:0] b;
		for (int i = 0; i < 8; i++) begin
			b[i] = ~crc[31 - i];
		end
		return b;
	endfunction

endpackage

/* source/apb_host_port.sv */
module apb_host_port
	import eth_mac_pkg::*;
(
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  psel_i,
	input  logic                  penable_i,
	input  logic                  pwrite_i,
	input  logic [APB_ADDR_W-1:0] paddr_i,
	input  logic [APB_DATA_W-1:0] pwdata_i,
	input  store_rsp_t            tx_rsp_i,
	input  store_rsp_t            rx_rsp_i,
	output logic [APB_DATA_W-1:0] prdata_o,
	output logic                  pready_o,
	output logic                  pslverr_o,
	output host_req_t             host_req_o
);

	logic       first_access;
	logic       second_q;                             // access counter, 2nd cycle
	logic       tx_sel_q;
	logic       bad_q;
	logic       idx_bad;
	logic       op_bad;
	store_rsp_t sel_rsp;

	assign first_access = psel_i && penable_i && !second_q;
	assign idx_bad      = paddr_i[7:0] >= PKT_BYTES;
	assign op_bad       = paddr_i[10:8] > OP_TX_NEXT;

	always_comb begin
		host_req_o.valid = first_access && !idx_bad && !op_bad;
		host_req_o.write = pwrite_i;
		host_req_o.op    = host_op_e'(paddr_i[10:8]);
		host_req_o.index = paddr_i[7:0];
		host_req_o.wdata = pwdata_i[7:0];
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			second_q <= 1'b0;
			tx_sel_q <= 1'b0;
			bad_q    <= 1'b0;
		end else begin
			second_q <= first_access;
			if (first_access) begin
				tx_sel_q <= paddr_i[10:8] >= OP_TX_BYTE;  // tx store owns the upper ops
				bad_q    <= idx_bad || op_bad;
			end
		end
	end

	assign sel_rsp   = tx_sel_q ? tx_rsp_i : rx_rsp_i;
	assign pready_o  = second_q;
	assign prdata_o  = bad_q ? '0 : APB_DATA_W'(sel_rsp.rdata);
	assign pslverr_o = second_q && (bad_q || sel_rsp.err);

	// master must hold the transfer open until the two access cycles are done
	assert property (@(posedge clock) disable iff (reset) psel_i && !pready_o |=> psel_i)
		else $error("psel dropped before pready");

endmodule

/* packet_store/tx_packet_store.sv */
module tx_packet_store
	import eth_mac_pkg::*;
(
	input  logic                  clock,
	input  logic                  reset,
	input  host_req_t             host_req_i,
	input  logic [BYTE_IDX_W-1:0] tx_rd_idx_i,
	input  logic                  tx_pop_i,
	output store_rsp_t            tx_rsp_o,
	output tx_head_t              tx_head_o,
	output logic [7:0]            tx_rd_data_o
);

	logic [7:0]            mem [RING_DEPTH][PKT_BYTES];
	logic [LEN_W-1:0]      len_q [RING_DEPTH];
	logic [RING_IDX_W-1:0] wr_ptr;                    // slot being filled by host
	logic [RING_IDX_W-1:0] send_ptr;
	logic [RING_IDX_W:0]   count;
	logic                  full;
	logic                  byte_wr;
	logic                  push;
	logic [BYTE_IDX_W-1:0] idx;
	logic [LEN_W-1:0]      byte_end;

	assign full     = count == RING_DEPTH;
	assign idx      = host_req_i.index[BYTE_IDX_W-1:0];
	assign byte_end = LEN_W'(idx) + 1'b1;
	assign byte_wr  = host_req_i.valid && host_req_i.op == OP_TX_BYTE && host_req_i.write && !full;
	assign push     = host_req_i.valid && host_req_i.op == OP_TX_NEXT && !full
		&& len_q[wr_ptr] != '0;

	always_ff @(posedge clock) begin
		if (byte_wr) begin
			mem[wr_ptr][idx] <= host_req_i.wdata;
		end
		tx_rd_data_o <= mem[send_ptr][tx_rd_idx_i];
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			wr_ptr   <= '0;
			send_ptr <= '0;
			count    <= '0;
			tx_rsp_o <= '0;
			for (int i = 0; i < RING_DEPTH; i++) begin
				len_q[i] <= '0;
			end
		end else begin
			tx_rsp_o <= '0;
			if (byte_wr && byte_end > len_q[wr_ptr]) begin
				len_q[wr_ptr] <= byte_end;
			end
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (tx_pop_i) begin
				len_q[send_ptr] <= '0;                // slot comes back empty
				send_ptr        <= send_ptr + 1'b1;
			end
			count <= count + {{RING_IDX_W{1'b0}}, push} - {{RING_IDX_W{1'b0}}, tx_pop_i};
			if (host_req_i.valid) begin
				case (host_req_i.op)
					OP_TX_BYTE: tx_rsp_o.err   <= !host_req_i.write || full;
					OP_TX_LEN:  tx_rsp_o.rdata <= 8'(len_q[wr_ptr]);
					OP_TX_NEXT: tx_rsp_o.err   <= !push;
					default:    tx_rsp_o       <= '0;
				endcase
			end
		end
	end

	assign tx_head_o.valid = count != '0;
	assign tx_head_o.len   = len_q[send_ptr];

	// framer may only release a packet it was offered
	assert property (@(posedge clock) disable iff (reset) tx_pop_i |-> tx_head_o.valid)
		else $error("tx pop while head invalid");

endmodule

/* packet_store/rx_packet_store.sv */
module rx_packet_store
	import eth_mac_pkg::*;
(
	input  logic       clock,
	input  logic       reset,
	input  host_req_t  host_req_i,
	input  rx_wr_t     rx_wr_i,
	output store_rsp_t rx_rsp_o,
	output logic       rx_full_o
);

	logic [7:0]            mem [RING_DEPTH][PKT_BYTES];
	logic [LEN_W-1:0]      len_q [RING_DEPTH];
	logic [RING_IDX_W-1:0] wr_ptr;                    // slot the framer fills
	logic [RING_IDX_W-1:0] rd_ptr;
	logic [RING_IDX_W:0]   count;
	logic [LEN_W-1:0]      fill_q;                    // bytes of the open frame
	logic                  pop;
	logic [BYTE_IDX_W-1:0] idx;

	assign rx_full_o = count == RING_DEPTH;
	assign idx       = host_req_i.index[BYTE_IDX_W-1:0];
	assign pop       = host_req_i.valid && host_req_i.op == OP_RX_NEXT && count != '0;

	always_ff @(posedge clock) begin
		if (rx_wr_i.we) begin
			mem[wr_ptr][rx_wr_i.index] <= rx_wr_i.data;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
			fill_q   <= '0;
			rx_rsp_o <= '0;
			for (int i = 0; i < RING_DEPTH; i++) begin
				len_q[i] <= '0;
			end
		end else begin
			rx_rsp_o <= '0;
			if (rx_wr_i.we) begin
				fill_q <= LEN_W'(rx_wr_i.index) + 1'b1;
			end
			if (rx_wr_i.commit || rx_wr_i.drop) begin
				fill_q <= '0;
			end
			if (rx_wr_i.commit) begin
				len_q[wr_ptr] <= rx_wr_i.len;
				wr_ptr        <= wr_ptr + 1'b1;
			end
			if (pop) begin
				len_q[rd_ptr] <= '0;
				rd_ptr        <= rd_ptr + 1'b1;
			end
			count <= count + {{RING_IDX_W{1'b0}}, rx_wr_i.commit} - {{RING_IDX_W{1'b0}}, pop};
			if (host_req_i.valid) begin
				case (host_req_i.op)
					OP_RX_BYTE: begin
						rx_rsp_o.err <= host_req_i.write;
						if (LEN_W'(idx) < len_q[rd_ptr]) begin
							rx_rsp_o.rdata <= mem[rd_ptr][idx];
						end
					end
					OP_RX_LEN:  rx_rsp_o.rdata <= 8'(len_q[rd_ptr]);  // empty slot reads 0
					OP_RX_NEXT: rx_rsp_o.err   <= !pop;
					default:    rx_rsp_o       <= '0;
				endcase
			end
		end
	end

	// committed length is what the framer wrote minus the stripped FCS,
	// and the framer never commits into a full ring
	assert property (@(posedge clock) disable iff (reset)
		rx_wr_i.commit |-> !rx_full_o && rx_wr_i.len + LEN_W'(FCS_LEN) == fill_q)
		else $error("rx commit inconsistent with written bytes");

endmodule

/* gmii_framer/gmii_tx_framer.sv */
module gmii_tx_framer
	import eth_mac_pkg::*;
(
	input  logic                  clock,
	input  logic                  reset,
	input  tx_head_t              tx_head_i,
	input  logic [7:0]            tx_rd_data_i,
	output logic [BYTE_IDX_W-1:0] tx_rd_idx_o,
	output logic                  tx_pop_o,
	output gmii_t                 gmii_tx_o
);

	tx_state_e        state;
	logic [LEN_W-1:0] cnt;                            // preamble, data, fcs or gap count
	logic [31:0]      crc;

	// --------------------------------------------------------------------------
	// output is registered, so each state loads the byte for the next cycle
	// and the read index runs one ahead of the byte being loaded

	always_ff @(posedge clock) begin
		if (reset) begin
			state     <= TX_IDLE;
			gmii_tx_o <= '0;
			tx_pop_o  <= 1'b0;
		end else begin
			tx_pop_o <= 1'b0;
			case (state)
				TX_IDLE: begin
					tx_rd_idx_o <= '0;
					if (tx_head_i.valid) begin
						gmii_tx_o.data <= PREAMBLE_BYTE;
						gmii_tx_o.en   <= 1'b1;
						cnt            <= LEN_W'(1);
						state          <= TX_PREAMBLE;
					end
				end
				TX_PREAMBLE: begin
					if (cnt < PREAMBLE_LEN) begin
						cnt <= cnt + 1'b1;
					end else begin
						gmii_tx_o.data <= SFD_BYTE;
						tx_rd_idx_o    <= BYTE_IDX_W'(1);  // byte 0 already on read port
						state          <= TX_SFD;
					end
				end
				TX_SFD: begin
					gmii_tx_o.data <= tx_rd_data_i;
					crc            <= crc32_next(tx_rd_data_i, CRC_INIT);
					tx_rd_idx_o    <= tx_rd_idx_o + 1'b1;
					cnt            <= LEN_W'(1);
					state          <= TX_DATA;
				end
				TX_DATA: begin
					if (cnt < tx_head_i.len) begin
						gmii_tx_o.data <= tx_rd_data_i;
						crc            <= crc32_next(tx_rd_data_i, crc);
						tx_rd_idx_o    <= tx_rd_idx_o + 1'b1;
						cnt            <= cnt + 1'b1;
					end else begin
						gmii_tx_o.data <= fcs_byte(crc);
						crc            <= {crc[23:0], 8'h00};
						cnt            <= LEN_W'(1);
						state          <= TX_FCS;
					end
				end
				TX_FCS: begin
					if (cnt < FCS_LEN) begin
						gmii_tx_o.data <= fcs_byte(crc);
						crc            <= {crc[23:0], 8'h00};
						cnt            <= cnt + 1'b1;
					end else begin
						gmii_tx_o <= '0;
						tx_pop_o  <= 1'b1;                // frame is out, free the slot
						cnt       <= LEN_W'(1);
						state     <= TX_GAP;
					end
				end
				TX_GAP: begin
					if (cnt < IFG_CYCLES) begin
						cnt <= cnt + 1'b1;
					end else begin
						state <= TX_IDLE;
					end
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

	// slot being sent stays offered until its pop
	assert property (@(posedge clock) disable iff (reset) gmii_tx_o.en |-> tx_head_i.valid)
		else $error("tx head invalid while frame on the wire");

endmodule

/* gmii_framer/gmii_rx_framer.sv */
module gmii_rx_framer
	import eth_mac_pkg::*;
(
	input  logic   clock,
	input  logic   reset,
	input  gmii_t  gmii_rx_i,
	input  logic   rx_full_i,
	output rx_wr_t rx_wr_o
);

	rx_state_e        state;
	logic [LEN_W-1:0] cnt;                            // bytes after SFD, FCS included
	logic [31:0]      crc;
	logic             frame_ok;

	assign frame_ok = crc == CRC_RESIDUE && cnt > FCS_LEN && cnt <= PKT_BYTES;

	always_ff @(posedge clock) begin
		if (reset) begin
			state   <= RX_IDLE;
			rx_wr_o <= '0;
		end else begin
			rx_wr_o.we     <= 1'b0;
			rx_wr_o.commit <= 1'b0;
			rx_wr_o.drop   <= 1'b0;
			case (state)
				RX_IDLE: begin
					if (gmii_rx_i.en) begin
						if (!gmii_rx_i.er && gmii_rx_i.data == PREAMBLE_BYTE) begin
							state <= RX_PREAMBLE;
						end else begin
							state <= RX_DISCARD;
						end
					end
				end
				RX_PREAMBLE: begin
					if (!gmii_rx_i.en) begin
						state <= RX_IDLE;
					end else if (gmii_rx_i.er) begin
						state <= RX_DISCARD;
					end else if (gmii_rx_i.data == SFD_BYTE) begin
						cnt   <= '0;
						crc   <= CRC_INIT;
						state <= rx_full_i ? RX_DISCARD : RX_DATA;  // no room, skip frame
					end else if (gmii_rx_i.data != PREAMBLE_BYTE) begin
						state <= RX_DISCARD;
					end
				end
				RX_DATA: begin
					if (!gmii_rx_i.en) begin
						if (frame_ok) begin
							rx_wr_o.commit <= 1'b1;
							rx_wr_o.len    <= cnt - LEN_W'(FCS_LEN);  // strip fcs
						end else begin
							rx_wr_o.drop <= 1'b1;
						end
						state <= RX_IDLE;
					end else if (gmii_rx_i.er || cnt == PKT_BYTES) begin
						rx_wr_o.drop <= 1'b1;
						state        <= RX_DISCARD;
					end else begin
						rx_wr_o.we    <= 1'b1;
						rx_wr_o.index <= cnt[BYTE_IDX_W-1:0];
						rx_wr_o.data  <= gmii_rx_i.data;
						crc           <= crc32_next(gmii_rx_i.data, crc);
						cnt           <= cnt + 1'b1;
					end
				end
				RX_DISCARD: begin
					if (!gmii_rx_i.en) begin
						state <= RX_IDLE;
					end
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

endmodule

/* source/eth_mac_top.sv */
module eth_mac_top
	import eth_mac_pkg::*;
(
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  psel_i,
	input  logic                  penable_i,
	input  logic                  pwrite_i,
	input  logic [APB_ADDR_W-1:0] paddr_i,
	input  logic [APB_DATA_W-1:0] pwdata_i,
	output logic [APB_DATA_W-1:0] prdata_o,
	output logic                  pready_o,
	output logic                  pslverr_o,
	output gmii_t                 gmii_tx_o,
	input  gmii_t                 gmii_rx_i
);

	host_req_t             host_req;
	store_rsp_t            tx_rsp;
	store_rsp_t            rx_rsp;
	tx_head_t              tx_head;
	logic [BYTE_IDX_W-1:0] tx_rd_idx;
	logic                  tx_pop;
	logic [7:0]            tx_rd_data;
	rx_wr_t                rx_wr;
	logic                  rx_full;

	apb_host_port host_port (
		.clock, .reset,
		.psel_i, .penable_i, .pwrite_i, .paddr_i, .pwdata_i,
		.tx_rsp_i   (tx_rsp),
		.rx_rsp_i   (rx_rsp),
		.prdata_o, .pready_o, .pslverr_o,
		.host_req_o (host_req)
	);

	tx_packet_store tx_store (
		.clock, .reset,
		.host_req_i   (host_req),
		.tx_rd_idx_i  (tx_rd_idx),
		.tx_pop_i     (tx_pop),
		.tx_rsp_o     (tx_rsp),
		.tx_head_o    (tx_head),
		.tx_rd_data_o (tx_rd_data)
	);

	rx_packet_store rx_store (
		.clock, .reset,
		.host_req_i (host_req),
		.rx_wr_i    (rx_wr),
		.rx_rsp_o   (rx_rsp),
		.rx_full_o  (rx_full)
	);

	gmii_tx_framer tx_framer (
		.clock, .reset,
		.tx_head_i    (tx_head),
		.tx_rd_data_i (tx_rd_data),
		.tx_rd_idx_o  (tx_rd_idx),
		.tx_pop_o     (tx_pop),
		.gmii_tx_o
	);

	gmii_rx_framer rx_framer (
		.clock, .reset,
		.gmii_rx_i,
		.rx_full_i (rx_full),
		.rx_wr_o   (rx_wr)
	);

endmodule

/* test/eth_mac_tb.sv */
module eth_mac_tb
	import eth_mac_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int WATCHDOG_NS   = 200_000;          // 40 frames of 90 cycles plus APB traffic
	localparam int PREADY_LIMIT  = 8;
	localparam int TX_DONE_LIMIT = 1000;             // cycles for a few queued frames
	localparam int MAX_PAYLOAD   = 72;

	logic                  clock;
	logic                  reset;
	logic                  psel;
	logic                  penable;
	logic                  pwrite;
	logic [APB_ADDR_W-1:0] paddr;
	logic [APB_DATA_W-1:0] pwdata;
	logic [APB_DATA_W-1:0] prdata;
	logic                  pready;
	logic                  pslverr;
	gmii_t                 gmii_tx;
	gmii_t                 gmii_rx;
	gmii_t                 rx_drive;
	logic                  loopback;

	int errors;
	int checks;

	logic [7:0] tx_exp_q [$];                        // expected frame bytes, all frames
	int         tx_exp_len_q [$];
	logic [7:0] tx_cap_q [$];                        // captured from gmii_tx
	int         tx_cap_len_q [$];

	logic [7:0] payload [5][MAX_PAYLOAD];
	int         pay_len [5];

	always #4 clock = ~clock;

	assign gmii_rx = loopback ? gmii_tx : rx_drive;

	eth_mac_top dut_i (
		.clock     (clock),
		.reset     (reset),
		.psel_i    (psel),
		.penable_i (penable),
		.pwrite_i  (pwrite),
		.paddr_i   (paddr),
		.pwdata_i  (pwdata),
		.prdata_o  (prdata),
		.pready_o  (pready),
		.pslverr_o (pslverr),
		.gmii_tx_o (gmii_tx),
		.gmii_rx_i (gmii_rx)
	);

	// --------------------------------------------------------------------------
	// reference model and helpers

	// standard reflected CRC-32, FCS byte k is bits [8k+7:8k]
	function automatic logic [31:0] ref_fcs(input int slot, input int len);
		logic [31:0] c;
		c = 32'hFFFF_FFFF;
		for (int i = 0; i < len; i++) begin
			c = c ^ {24'h0, payload[slot][i]};
			for (int b = 0; b < 8; b++) begin
				c = c[0] ? (c >> 1) ^ 32'hEDB8_8320 : c >> 1;
			end
		end
		return ~c;
	endfunction

	task automatic make_payload(input int slot, input int len);
		pay_len[slot] = len;
		for (int i = 0; i < len; i++) begin
			payload[slot][i] = 8'($urandom);
		end
	endtask

	task automatic check_value(input string name, input int expected, input int actual);
		checks++;
		if (actual != expected) begin
			errors++;
			$display("[FAIL] %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
		end
	endtask

	// setup, two access cycles, then idle
	task automatic apb_transfer(input logic write, input host_op_e op, input int index,
			input logic [7:0] wdata, output logic [7:0] rdata, output logic err);
		int waited;
		waited = 0;
		@(negedge clock);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = write;
		paddr   = APB_ADDR_W'({op, 8'(index)});
		pwdata  = {24'h0, wdata};
		@(negedge clock);
		penable = 1'b1;
		@(negedge clock);
		while (!pready && waited < PREADY_LIMIT) begin
			@(negedge clock);
			waited++;
		end
		if (!pready) begin
			errors++;
			$display("APB transfer %s index %0d never saw pready", op.name(), index);
		end
		rdata = prdata[7:0];
		err   = pslverr;
		@(negedge clock);
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic write_reg(input host_op_e op, input int index, input logic [7:0] wdata,
			output logic err);
		logic [7:0] unused;
		apb_transfer(1'b1, op, index, wdata, unused, err);
	endtask

	task automatic read_reg(input host_op_e op, input int index, output logic [7:0] rdata,
			output logic err);
		apb_transfer(1'b0, op, index, 8'h00, rdata, err);
	endtask

	task automatic write_tx_bytes(input int slot);
		logic err;
		for (int i = 0; i < pay_len[slot]; i++) begin
			write_reg(OP_TX_BYTE, i, payload[slot][i], err);
			check_value("tx byte write err", 0, err);
		end
	endtask

	task automatic commit_tx_packet(input int slot);
		logic        err;
		logic [31:0] fcs;
		fcs = ref_fcs(slot, pay_len[slot]);
		repeat (7) tx_exp_q.push_back(8'h55);
		tx_exp_q.push_back(8'hD5);
		for (int i = 0; i < pay_len[slot]; i++) begin
			tx_exp_q.push_back(payload[slot][i]);
		end
		for (int k = 0; k < 4; k++) begin
			tx_exp_q.push_back(fcs[8*k +: 8]);
		end
		tx_exp_len_q.push_back(12 + pay_len[slot]);
		write_reg(OP_TX_NEXT, 0, 8'h00, err);
		check_value("tx commit err", 0, err);
	endtask

	task automatic wait_tx_done();
		int waited;
		waited = 0;
		while ((tx_exp_len_q.size() != 0 || tx_cap_len_q.size() != 0)
				&& waited < TX_DONE_LIMIT) begin
			@(negedge clock);
			waited++;
		end
		if (tx_exp_len_q.size() != 0) begin
			errors++;
			$display("%0d transmit frames missing after %0d cycles",
				tx_exp_len_q.size(), TX_DONE_LIMIT);
		end
	endtask

	// er_at is a frame byte position, -1 for a clean frame
	task automatic send_rx_frame(input int slot, input logic bad_fcs, input int er_at);
		logic [31:0] fcs;
		logic [7:0]  frame [$];
		fcs = ref_fcs(slot, pay_len[slot]);
		if (bad_fcs) begin
			fcs = fcs ^ 32'h0000_0100;
		end
		repeat (7) frame.push_back(8'h55);
		frame.push_back(8'hD5);
		for (int i = 0; i < pay_len[slot]; i++) begin
			frame.push_back(payload[slot][i]);
		end
		for (int k = 0; k < 4; k++) begin
			frame.push_back(fcs[8*k +: 8]);
		end
		foreach (frame[i]) begin
			@(negedge clock);
			rx_drive.en   = 1'b1;
			rx_drive.data = frame[i];
			rx_drive.er   = i == er_at;
		end
		@(negedge clock);
		rx_drive = '0;
		repeat (IFG_CYCLES) @(negedge clock);        // frame visible within 3 cycles
	endtask

	task automatic check_rx_packet(input string name, input int slot);
		logic [7:0] data;
		logic       err;
		read_reg(OP_RX_LEN, 0, data, err);
		check_value({name, " length"}, pay_len[slot], data);
		for (int i = 0; i < pay_len[slot]; i++) begin
			read_reg(OP_RX_BYTE, i, data, err);
			check_value($sformatf("%s byte %0d", name, i), payload[slot][i], data);
		end
		read_reg(OP_RX_BYTE, pay_len[slot], data, err);
		check_value({name, " byte past length"}, 0, data);
		write_reg(OP_RX_NEXT, 0, 8'h00, err);
		check_value({name, " release err"}, 0, err);
	endtask

	task automatic check_rx_empty(input string name);
		logic [7:0] data;
		logic       err;
		read_reg(OP_RX_LEN, 0, data, err);
		check_value({name, " length"}, 0, data);
		write_reg(OP_RX_NEXT, 0, 8'h00, err);
		check_value({name, " release err"}, 1, err);
	endtask

	// --------------------------------------------------------------------------
	// transmit monitor and compare

	initial begin
		int   frame_len;
		int   idle;
		logic seen;
		frame_len = 0;
		idle      = 0;
		seen      = 1'b0;
		forever begin
			@(negedge clock);
			if (!reset && gmii_tx.en) begin
				if (frame_len == 0 && seen && idle < IFG_CYCLES) begin
					errors++;
					$display("[FAIL] tx gap: expected >= %0d, actual %0d", IFG_CYCLES, idle);
				end
				if (gmii_tx.er) begin
					errors++;
					$display("tx er went high inside a frame");
				end
				tx_cap_q.push_back(gmii_tx.data);
				frame_len++;
				idle = 0;
			end else begin
				if (frame_len != 0) begin
					tx_cap_len_q.push_back(frame_len);
					seen = 1'b1;
				end
				frame_len = 0;
				idle++;
			end
		end
	end

	initial begin
		int         cap_len;
		int         exp_len;
		logic [7:0] cap_b;
		logic [7:0] exp_b;
		forever begin
			@(negedge clock);
			if (tx_cap_len_q.size() != 0) begin
				cap_len = tx_cap_len_q.pop_front();
				exp_len = 0;
				if (tx_exp_len_q.size() == 0) begin
					errors++;
					$display("tx frame of %0d bytes sent with none expected", cap_len);
				end else begin
					exp_len = tx_exp_len_q.pop_front();
					check_value("tx frame length", exp_len, cap_len);
				end
				for (int i = 0; i < cap_len || i < exp_len; i++) begin
					cap_b = 8'h00;
					exp_b = 8'h00;
					if (i < cap_len) begin
						cap_b = tx_cap_q.pop_front();
					end
					if (i < exp_len) begin
						exp_b = tx_exp_q.pop_front();
					end
					if (i < cap_len && i < exp_len) begin
						check_value($sformatf("tx frame byte %0d", i), exp_b, cap_b);
					end
				end
			end
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, run stopped", WATCHDOG_NS);
		$display("ERRORS FOUND");
		$finish;
	end

	// --------------------------------------------------------------------------
	// test sequence

	initial begin
		logic [7:0] data;
		logic       err;
		void'($urandom(99591));
		clock    = 1'b0;
		reset    = 1'b1;
		psel     = 1'b0;
		penable  = 1'b0;
		pwrite   = 1'b0;
		paddr    = '0;
		pwdata   = '0;
		rx_drive = '0;
		loopback = 1'b0;
		errors   = 0;
		checks   = 0;
		repeat (5) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;

		// transmit errors and fill length
		write_reg(OP_TX_NEXT, 0, 8'h00, err);
		check_value("tx commit empty packet err", 1, err);
		write_reg(OP_TX_BYTE, PKT_BYTES, 8'hA5, err);
		check_value("tx byte index 64 err", 1, err);
		make_payload(0, 6);
		write_reg(OP_TX_BYTE, 0, payload[0][0], err);
		read_reg(OP_TX_LEN, 0, data, err);
		check_value("tx length after index 0", 1, data);
		write_reg(OP_TX_BYTE, 5, payload[0][5], err);
		read_reg(OP_TX_LEN, 0, data, err);
		check_value("tx length after index 5", 6, data);
		write_reg(OP_TX_BYTE, 2, payload[0][2], err);
		read_reg(OP_TX_LEN, 0, data, err);
		check_value("tx length after index 2", 6, data);
		write_reg(OP_TX_BYTE, 1, payload[0][1], err);
		write_reg(OP_TX_BYTE, 3, payload[0][3], err);
		write_reg(OP_TX_BYTE, 4, payload[0][4], err);
		commit_tx_packet(0);
		wait_tx_done();

		// transmit format, frames queued back to back
		for (int s = 0; s < 3; s++) begin
			make_payload(s, 1 + int'($urandom % 60));
			write_tx_bytes(s);
			commit_tx_packet(s);
		end
		wait_tx_done();

		// receive good and bad frames
		make_payload(0, 1 + int'($urandom % 60));
		send_rx_frame(0, 1'b0, -1);
		check_rx_packet("rx good frame", 0);
		make_payload(0, 20);
		send_rx_frame(0, 1'b1, -1);
		check_rx_empty("rx bad fcs");
		send_rx_frame(0, 1'b0, 12);
		check_rx_empty("rx er pulse");
		make_payload(0, 66);
		send_rx_frame(0, 1'b0, -1);
		check_rx_empty("rx oversize");

		// receive ring full, fifth frame dropped
		for (int s = 0; s < 5; s++) begin
			make_payload(s, 1 + int'($urandom % 60));
			send_rx_frame(s, 1'b0, -1);
		end
		for (int s = 0; s < 4; s++) begin
			check_rx_packet($sformatf("rx ring packet %0d", s), s);
		end
		write_reg(OP_RX_NEXT, 0, 8'h00, err);
		check_value("rx fifth release err", 1, err);

		// loopback through both paths
		@(negedge clock);
		loopback = 1'b1;
		for (int s = 0; s < 3; s++) begin
			make_payload(s, 1 + int'($urandom % 60));
			write_tx_bytes(s);
			commit_tx_packet(s);
		end
		wait_tx_done();
		repeat (4) @(negedge clock);
		for (int s = 0; s < 3; s++) begin
			check_rx_packet($sformatf("loopback packet %0d", s), s);
		end
		check_rx_empty("loopback drained");

		$display("checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

/* compile.f */
common/eth_mac_pkg.sv
source/apb_host_port.sv
packet_store/tx_packet_store.sv
packet_store/rx_packet_store.sv
gmii_framer/gmii_tx_framer.sv
gmii_framer/gmii_rx_framer.sv
source/eth_mac_top.sv
test/eth_mac_tb.sv

/* run.sh */
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
	-f compile.f --top-module eth_mac_tb -o eth_mac_sim &&
obj_dir/eth_mac_sim | tee /dev/stderr | grep -q "^NO ERRORS$" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
